/* clint_subsys.f */
src/clint_cfg_pkg.sv
src/clint_reg_pkg.sv
src/clint_req_decode.sv
src/clint_hart_ctrl.sv
src/clint_mtime_counter.sv
src/clint_resp_gen.sv
src/clint_top.sv
sim/clint_sva.sv
sim/tb_clint.sv

/* sim/tb_clint.sv */
// CLINT subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clint
  import clint_cfg_pkg::*;
  import clint_reg_pkg::*;
();

  localparam int TIMEOUT   = 200;
  localparam int DRIVE_DLY = 10;

  logic                  clk_i = 1'b0;
  logic                  rtc_i = 1'b0;
  logic                  ndmreset_n;
  logic                  awvalid;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awready;
  logic                  wvalid;
  logic [AXI_DATA_W-1:0] wdata;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  wready;
  logic                  bvalid;
  logic [1:0]            bresp;
  logic                  bready;
  logic                  arvalid;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arready;
  logic                  rvalid;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rready;
  logic [NUM_HARTS-1:0]  timer_irq;
  logic [NUM_HARTS-1:0]  ipi;

  // Register model
  logic [NUM_HARTS-1:0]  m_msip;
  logic [MTIME_W-1:0]    m_cmp [NUM_HARTS];

  string test_name;
  int    test_errs;
  int    err_count;
  int    check_count;
  int    test_count;

  always #50 clk_i = ~clk_i;
  always #1530 rtc_i = ~rtc_i;

  clint_top UUT (
    .clk_i       ( clk_i      ), .ndmreset_n  ( ndmreset_n ), .rtc_i       ( rtc_i      ),
    .s_awvalid_i ( awvalid    ), .s_awaddr_i  ( awaddr     ), .s_awready_o ( awready    ),
    .s_wvalid_i  ( wvalid     ), .s_wdata_i   ( wdata      ), .s_wstrb_i   ( wstrb      ),
    .s_wready_o  ( wready     ), .s_bvalid_o  ( bvalid     ), .s_bresp_o   ( bresp      ),
    .s_bready_i  ( bready     ), .s_arvalid_i ( arvalid    ), .s_araddr_i  ( araddr     ),
    .s_arready_o ( arready    ), .s_rvalid_o  ( rvalid     ), .s_rdata_o   ( rdata      ),
    .s_rresp_o   ( rresp      ), .s_rready_i  ( rready     ),
    .timer_irq_o ( timer_irq  ), .ipi_o       ( ipi        )
  );

  // ------------------------------------------------------------------
  // Address map and model helpers
  // ------------------------------------------------------------------
  function automatic logic [15:0] msip_addr(input int hart);
    return 16'(hart) << 2;
  endfunction

  function automatic logic [15:0] cmp_addr(input int hart, input logic half);
    return 16'h4000 | (16'(hart) << 3) | (16'(half) << 2);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic report_timeout(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("MISMATCH %s %s expected %08h actual %08h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("%s: %s", test_name, what);
      test_errs++;
    end
  endtask

  task automatic finish_test();
    $display("%-18s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed", test_errs);
    err_count += test_errs;
    test_errs = 0;
    test_count++;
  endtask

  // ------------------------------------------------------------------
  // AXI4-Lite master transfers
  // ------------------------------------------------------------------
  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int cnt;
    int stall;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    cnt     = 0;
    @(negedge clk_i);
    while (!(awready && wready)) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("awready and wready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Random write response back-pressure
    stall   = $urandom_range(3);
    bready  = (stall == 0);
    cnt     = 0;
    while (!bvalid) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("bvalid");
      @(negedge clk_i);
    end
    resp = bresp;
    if (stall > 0) begin
      repeat (stall) @(posedge clk_i);
      #DRIVE_DLY;
      bready = 1'b1;
    end
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cnt;
    arvalid = 1'b1;
    araddr  = addr;
    cnt     = 0;
    @(negedge clk_i);
    while (!arready) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("arready");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    arvalid = 1'b0;
    cnt     = 0;
    while (!rvalid) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("rvalid");
      @(negedge clk_i);
    end
    data = rdata;
    resp = rresp;
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic wait_irq_level(input int hart, input logic level);
    int cnt;
    cnt = 0;
    while (timer_irq[hart] !== level) begin
      cnt++;
      if (cnt > TIMEOUT) report_timeout("timer_irq_o level");
      @(negedge clk_i);
    end
  endtask

  // Reads every register back and compares with the model
  task automatic check_all_regs();
    logic [31:0] data;
    logic [1:0]  resp;
    for (int h = 0; h < NUM_HARTS; h++) begin
      axi_read(msip_addr(h), data, resp);
      check_value("msip", {31'd0, m_msip[h]}, data);
      check_value("rresp", RESP_OKAY, resp);
      axi_read(cmp_addr(h, 1'b0), data, resp);
      check_value("mtimecmp lo", m_cmp[h][31:0], data);
      check_value("rresp", RESP_OKAY, resp);
      axi_read(cmp_addr(h, 1'b1), data, resp);
      check_value("mtimecmp hi", m_cmp[h][63:32], data);
      check_value("rresp", RESP_OKAY, resp);
    end
    check_value("ipi_o", 32'(m_msip), 32'(ipi));
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    logic [31:0] data;
    logic [31:0] t1;
    logic [31:0] t2;
    logic [3:0]  strb;
    logic [1:0]  resp;
    logic        half;
    int          kind;
    int          h;
    int          hold;
    int          cnt;

    void'($urandom(74546));
    ndmreset_n = 1'b0;
    {awvalid, wvalid, arvalid} = '0;
    awaddr = '0;
    araddr = '0;
    wdata  = '0;
    wstrb  = '0;
    bready = 1'b1;
    rready = 1'b1;
    m_msip = '0;
    for (int i = 0; i < NUM_HARTS; i++) m_cmp[i] = '1;
    {test_errs, err_count, check_count, test_count} = '0;
    repeat (8) @(posedge clk_i);
    #DRIVE_DLY;
    ndmreset_n = 1'b1;

    test_name = "reset_state";
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    check_all_regs();
    finish_test();

    test_name = "reg_write_read";
    for (int i = 0; i < 200; i++) begin
      kind = $urandom_range(2);
      h    = $urandom_range(NUM_HARTS - 1);
      data = $urandom;
      strb = $urandom_range(15);
      half = (kind == 2);
      axi_write((kind == 0) ? msip_addr(h) : cmp_addr(h, half), data, strb, resp);
      check_value("bresp", RESP_OKAY, resp);
      if (kind == 0) begin
        if (strb[0]) m_msip[h] = data[0];
        axi_read(msip_addr(h), data, resp);
        check_value("msip", {31'd0, m_msip[h]}, data);
      end else if (half) begin
        m_cmp[h][63:32] = merge_bytes(m_cmp[h][63:32], data, strb);
        axi_read(cmp_addr(h, 1'b1), data, resp);
        check_value("mtimecmp hi", m_cmp[h][63:32], data);
      end else begin
        m_cmp[h][31:0] = merge_bytes(m_cmp[h][31:0], data, strb);
        axi_read(cmp_addr(h, 1'b0), data, resp);
        check_value("mtimecmp lo", m_cmp[h][31:0], data);
      end
      check_value("rresp", RESP_OKAY, resp);
      check_value("ipi_o", 32'(m_msip), 32'(ipi));
    end
    finish_test();

    test_name = "mtime_advance";
    axi_read(16'hC000, t1, resp);
    repeat (100) @(posedge clk_i);
    #DRIVE_DLY;
    axi_read(16'hC000, t2, resp);
    check_cond(t2 > t1, "mtime did not advance over 100 cycles");
    axi_write(16'hC000, 32'd0, 4'hF, resp);
    check_value("bresp", RESP_SLVERR, resp);
    axi_read(16'hC000, t1, resp);
    check_cond(t1 >= t2, "mtime went backwards after a write");
    finish_test();

    test_name = "timer_irq";
    for (int i = 0; i < NUM_HARTS; i++) begin
      axi_write(cmp_addr(i, 1'b0), 32'hFFFF_FFFF, 4'hF, resp);
      axi_write(cmp_addr(i, 1'b1), 32'hFFFF_FFFF, 4'hF, resp);
      m_cmp[i] = '1;
    end
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    h = $urandom_range(NUM_HARTS - 1);
    axi_write(cmp_addr(h, 1'b0), 32'd0, 4'hF, resp);
    axi_write(cmp_addr(h, 1'b1), 32'd0, 4'hF, resp);
    wait_irq_level(h, 1'b1);
    check_value("timer_irq_o", 32'(1) << h, 32'(timer_irq));
    axi_write(cmp_addr(h, 1'b1), 32'hFFFF_FFFF, 4'hF, resp);
    wait_irq_level(h, 1'b0);
    check_value("timer_irq_o", 32'd0, 32'(timer_irq));
    axi_write(cmp_addr(h, 1'b0), 32'hFFFF_FFFF, 4'hF, resp);
    finish_test();

    test_name = "unmapped_access";
    for (int i = 0; i < 8; i++) begin
      t1 = 32'h8000 | ($urandom & 32'h3FFF);
      axi_write(t1[15:0], $urandom, 4'hF, resp);
      check_value("bresp", RESP_SLVERR, resp);
      axi_read(t1[15:0], data, resp);
      check_value("rdata", 32'd0, data);
      check_value("rresp", RESP_SLVERR, resp);
    end
    for (int i = 1; i < NUM_HARTS; i++) begin
      half = $urandom_range(1);
      t1 = 32'hC000 | (i << 3) | (32'(half) << 2);
      axi_read(t1[15:0], data, resp);
      check_value("rdata", 32'd0, data);
      check_value("rresp", RESP_SLVERR, resp);
      axi_write(t1[15:0], $urandom, 4'hF, resp);
      check_value("bresp", RESP_SLVERR, resp);
    end
    check_all_regs();
    finish_test();

    test_name = "read_backpressure";
    for (int i = 0; i < 10; i++) begin
      h    = $urandom_range(NUM_HARTS - 1);
      half = $urandom_range(1);
      hold = $urandom_range(20, 1);
      data = $urandom;
      // Distinct value in the half under test
      axi_write(cmp_addr(h, half), data, 4'hF, resp);
      check_value("bresp", RESP_OKAY, resp);
      if (half) begin
        m_cmp[h][63:32] = data;
      end else begin
        m_cmp[h][31:0] = data;
      end
      rready  = 1'b0;
      arvalid = 1'b1;
      araddr  = cmp_addr(h, half);
      cnt     = 0;
      @(negedge clk_i);
      while (!arready) begin
        cnt++;
        if (cnt > TIMEOUT) report_timeout("arready");
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #DRIVE_DLY;
      // Second read waits behind the stalled response
      araddr = msip_addr(h);
      repeat (hold) begin
        @(negedge clk_i);
        check_cond(rvalid, "rvalid dropped while rready was low");
        check_value("held rdata", half ? m_cmp[h][63:32] : m_cmp[h][31:0], rdata);
        check_value("held rresp", RESP_OKAY, rresp);
        check_cond(!arready, "second read accepted while a response was pending");
      end
      @(posedge clk_i);
      #DRIVE_DLY;
      rready = 1'b1;
      axi_read(msip_addr(h), data, resp);
      check_value("msip", {31'd0, m_msip[h]}, data);
    end
    finish_test();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_clint

`default_nettype wire

/* sim/clint_sva.sv */
// CLINT handshake and reset assertions
`timescale 1ns/1ps
`default_nettype none

module clint_sva
  import clint_cfg_pkg::*;
(
  input logic                  clk_i,
  input logic                  ndmreset_n,
  input logic                  s_bvalid_o,
  input logic                  s_bready_i,
  input logic [1:0]            s_bresp_o,
  input logic                  s_rvalid_o,
  input logic                  s_rready_i,
  input logic [AXI_DATA_W-1:0] s_rdata_o,
  input logic [1:0]            s_rresp_o,
  input logic                  s_arready_o,
  input logic [NUM_HARTS-1:0]  timer_irq_o,
  input logic [NUM_HARTS-1:0]  ipi_o
);

  // Write response held until the master takes it
  a_b_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
    else $error("write response dropped or changed before bready");

  // Read response held with stable data
  a_r_hold: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
    else $error("read response dropped or changed before rready");

  // Single outstanding read
  a_ar_block: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    s_rvalid_o |-> !s_arready_o)
    else $error("arready high while a read response is pending");

  // ------------------------------------------------------------------
  // Interrupts quiet on reset release
  // ------------------------------------------------------------------
  a_irq_reset: assert property (@(posedge clk_i)
    $rose(ndmreset_n) |-> (ipi_o == '0) && (timer_irq_o == '0))
    else $error("interrupt output high right after reset release");

endmodule : clint_sva

bind clint_top clint_sva i_clint_sva (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .s_bvalid_o  ( s_bvalid_o  ),
  .s_bready_i  ( s_bready_i  ),
  .s_bresp_o   ( s_bresp_o   ),
  .s_rvalid_o  ( s_rvalid_o  ),
  .s_rready_i  ( s_rready_i  ),
  .s_rdata_o   ( s_rdata_o   ),
  .s_rresp_o   ( s_rresp_o   ),
  .s_arready_o ( s_arready_o ),
  .timer_irq_o ( timer_irq_o ),
  .ipi_o       ( ipi_o       )
);

`default_nettype wire

/* src/clint_top.sv */
// CLINT subsystem top
`timescale 1ns/1ps
`default_nettype none

module clint_top
  import clint_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  // AXI4-Lite slave
  input  logic                  s_awvalid_i,
  input  logic [AXI_ADDR_W-1:0] s_awaddr_i,
  output logic                  s_awready_o,
  input  logic                  s_wvalid_i,
  input  logic [AXI_DATA_W-1:0] s_wdata_i,
  input  logic [AXI_STRB_W-1:0] s_wstrb_i,
  output logic                  s_wready_o,
  output logic                  s_bvalid_o,
  output logic [1:0]            s_bresp_o,
  input  logic                  s_bready_i,
  input  logic                  s_arvalid_i,
  input  logic [AXI_ADDR_W-1:0] s_araddr_i,
  output logic                  s_arready_o,
  output logic                  s_rvalid_o,
  output logic [AXI_DATA_W-1:0] s_rdata_o,
  output logic [1:0]            s_rresp_o,
  input  logic                  s_rready_i,
  // Interrupts per hart
  output logic [NUM_HARTS-1:0]  timer_irq_o,
  output logic [NUM_HARTS-1:0]  ipi_o
);

  logic [NUM_HARTS-1:0]              wr_msip;
  logic [NUM_HARTS-1:0]              wr_cmp_lo;
  logic [NUM_HARTS-1:0]              wr_cmp_hi;
  logic [AXI_DATA_W-1:0]             wdata;
  logic [AXI_STRB_W-1:0]             wstrb;
  logic                              wr_done;
  logic                              wr_err;
  logic                              rd_req;
  logic [1:0]                        rd_region;
  logic [HART_IDX_W-1:0]             rd_hart;
  logic                              rd_half;
  logic                              rd_err;
  logic                              b_busy;
  logic                              r_busy;
  logic [NUM_HARTS-1:0]              msip;
  logic [NUM_HARTS-1:0][MTIME_W-1:0] mtimecmp;
  logic [MTIME_W-1:0]                mtime;

  clint_req_decode i_req_decode (
    .s_awvalid_i ( s_awvalid_i ),
    .s_awaddr_i  ( s_awaddr_i  ),
    .s_awready_o ( s_awready_o ),
    .s_wvalid_i  ( s_wvalid_i  ),
    .s_wdata_i   ( s_wdata_i   ),
    .s_wstrb_i   ( s_wstrb_i   ),
    .s_wready_o  ( s_wready_o  ),
    .s_arvalid_i ( s_arvalid_i ),
    .s_araddr_i  ( s_araddr_i  ),
    .s_arready_o ( s_arready_o ),
    .b_busy_i    ( b_busy      ),
    .r_busy_i    ( r_busy      ),
    .wr_msip_o   ( wr_msip     ),
    .wr_cmp_lo_o ( wr_cmp_lo   ),
    .wr_cmp_hi_o ( wr_cmp_hi   ),
    .wdata_o     ( wdata       ),
    .wstrb_o     ( wstrb       ),
    .wr_done_o   ( wr_done     ),
    .wr_err_o    ( wr_err      ),
    .rd_req_o    ( rd_req      ),
    .rd_region_o ( rd_region   ),
    .rd_hart_o   ( rd_hart     ),
    .rd_half_o   ( rd_half     ),
    .rd_err_o    ( rd_err      )
  );

  // ------------------------------------------------------------------
  // One controller per hart
  // ------------------------------------------------------------------
  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    clint_hart_ctrl i_hart_ctrl (
      .clk_i       ( clk_i          ),
      .ndmreset_n  ( ndmreset_n     ),
      .wr_msip_i   ( wr_msip[h]     ),
      .wr_cmp_lo_i ( wr_cmp_lo[h]   ),
      .wr_cmp_hi_i ( wr_cmp_hi[h]   ),
      .wdata_i     ( wdata          ),
      .wstrb_i     ( wstrb          ),
      .mtime_i     ( mtime          ),
      .msip_o      ( msip[h]        ),
      .mtimecmp_o  ( mtimecmp[h]    ),
      .timer_irq_o ( timer_irq_o[h] ),
      .ipi_o       ( ipi_o[h]       )
    );
  end

  clint_mtime_counter i_mtime_counter (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rtc_i      ( rtc_i      ),
    .mtime_o    ( mtime      )
  );

  clint_resp_gen i_resp_gen (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .wr_done_i   ( wr_done     ),
    .wr_err_i    ( wr_err      ),
    .rd_req_i    ( rd_req      ),
    .rd_region_i ( rd_region   ),
    .rd_hart_i   ( rd_hart     ),
    .rd_half_i   ( rd_half     ),
    .rd_err_i    ( rd_err      ),
    .msip_i      ( msip        ),
    .mtimecmp_i  ( mtimecmp    ),
    .mtime_i     ( mtime       ),
    .s_bready_i  ( s_bready_i  ),
    .s_bvalid_o  ( s_bvalid_o  ),
    .s_bresp_o   ( s_bresp_o   ),
    .s_rready_i  ( s_rready_i  ),
    .s_rvalid_o  ( s_rvalid_o  ),
    .s_rdata_o   ( s_rdata_o   ),
    .s_rresp_o   ( s_rresp_o   ),
    .b_busy_o    ( b_busy      ),
    .r_busy_o    ( r_busy      )
  );

endmodule : clint_top

`default_nettype wire

/* src/clint_resp_gen.sv */
// CLINT response generator
`timescale 1ns/1ps
`default_nettype none

module clint_resp_gen
  import clint_cfg_pkg::*;
  import clint_reg_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              ndmreset_n,
  // Requests from the decoder
  input  logic                              wr_done_i,
  input  logic                              wr_err_i,
  input  logic                              rd_req_i,
  input  logic [1:0]                        rd_region_i,
  input  logic [HART_IDX_W-1:0]             rd_hart_i,
  input  logic                              rd_half_i,
  input  logic                              rd_err_i,
  // Register state
  input  logic [NUM_HARTS-1:0]              msip_i,
  input  logic [NUM_HARTS-1:0][MTIME_W-1:0] mtimecmp_i,
  input  logic [MTIME_W-1:0]                mtime_i,
  // AXI4-Lite response channels
  input  logic                              s_bready_i,
  output logic                              s_bvalid_o,
  output logic [1:0]                        s_bresp_o,
  input  logic                              s_rready_i,
  output logic                              s_rvalid_o,
  output logic [AXI_DATA_W-1:0]             s_rdata_o,
  output logic [1:0]                        s_rresp_o,
  output logic                              b_busy_o,
  output logic                              r_busy_o
);

  logic [AXI_DATA_W-1:0] rd_data;
  logic [MTIME_W-1:0]    cmp_sel;

  // ------------------------------------------------------------------
  // Write response
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      s_bvalid_o <= 1'b0;
    end else if (wr_done_i) begin
      s_bvalid_o <= 1'b1;
    end else if (s_bready_i) begin
      s_bvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_done_i) begin
      s_bresp_o <= wr_err_i ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // ------------------------------------------------------------------
  // Readback mux
  // ------------------------------------------------------------------
  assign cmp_sel = mtimecmp_i[rd_hart_i];

  always_comb begin
    rd_data = '0;
    case (rd_region_i)
      REGION_MSIP:     rd_data = AXI_DATA_W'(msip_i[rd_hart_i]);
      REGION_MTIMECMP: rd_data = rd_half_i ? cmp_sel[MTIME_W-1:AXI_DATA_W]
                                           : cmp_sel[AXI_DATA_W-1:0];
      REGION_MTIME:    rd_data = rd_half_i ? mtime_i[MTIME_W-1:AXI_DATA_W]
                                           : mtime_i[AXI_DATA_W-1:0];
      default:         rd_data = '0;
    endcase
    // Errors return zero data
    if (rd_err_i) begin
      rd_data = '0;
    end
  end

  // Read response, data sampled in the handshake cycle
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      s_rvalid_o <= 1'b0;
    end else if (rd_req_i) begin
      s_rvalid_o <= 1'b1;
    end else if (s_rready_i) begin
      s_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_req_i) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_err_i ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign b_busy_o = s_bvalid_o;
  assign r_busy_o = s_rvalid_o;

endmodule : clint_resp_gen

`default_nettype wire

/* src/clint_mtime_counter.sv */
// CLINT mtime counter
`timescale 1ns/1ps
`default_nettype none

module clint_mtime_counter
  import clint_cfg_pkg::*;
(
  input  logic               clk_i,
  input  logic               ndmreset_n,
  input  logic               rtc_i,
  output logic [MTIME_W-1:0] mtime_o
);

  logic [RTC_SYNC_STAGES-1:0] rtc_sync;
  logic                       rtc_prev;
  logic                       rtc_rise;
  logic                       rtc_div;

  // Bring rtc into the clk_i domain and keep the last sample
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync <= '0;
      rtc_prev <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[RTC_SYNC_STAGES-2:0], rtc_i};
      rtc_prev <= rtc_sync[RTC_SYNC_STAGES-1];
    end
  end

  assign rtc_rise = rtc_sync[RTC_SYNC_STAGES-1] & ~rtc_prev;

  // ------------------------------------------------------------------
  // Divide by two, count on every second rtc edge
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_div <= 1'b0;
      mtime_o <= '0;
    end else if (rtc_rise) begin
      rtc_div <= ~rtc_div;
      if (rtc_div) begin
        mtime_o <= mtime_o + 1'b1;
      end
    end
  end

endmodule : clint_mtime_counter

`default_nettype wire

/* src/clint_hart_ctrl.sv */
// CLINT per-hart controller
`timescale 1ns/1ps
`default_nettype none

module clint_hart_ctrl
  import clint_cfg_pkg::*;
  import clint_reg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  wr_msip_i,
  input  logic                  wr_cmp_lo_i,
  input  logic                  wr_cmp_hi_i,
  input  logic [AXI_DATA_W-1:0] wdata_i,
  input  logic [AXI_STRB_W-1:0] wstrb_i,
  input  logic [MTIME_W-1:0]    mtime_i,
  output logic                  msip_o,
  output logic [MTIME_W-1:0]    mtimecmp_o,
  output logic                  timer_irq_o,
  output logic                  ipi_o
);

  logic msip;

  // Software interrupt, only byte 0 bit 0 is implemented
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip <= 1'b0;
    end else if (wr_msip_i && wstrb_i[0]) begin
      msip <= wdata_i[0];
    end
  end

  assign msip_o = msip;
  assign ipi_o  = msip;

  // ------------------------------------------------------------------
  // Timer compare, byte merge into the addressed half
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_o <= MTIMECMP_RESET;
    end else begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        if (wr_cmp_lo_i && wstrb_i[b]) begin
          mtimecmp_o[8*b +: 8] <= wdata_i[8*b +: 8];
        end
        if (wr_cmp_hi_i && wstrb_i[b]) begin
          mtimecmp_o[AXI_DATA_W+8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Level interrupt, one cycle behind mtime and mtimecmp
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= (mtime_i >= mtimecmp_o);
    end
  end

endmodule : clint_hart_ctrl

`default_nettype wire

/* src/clint_req_decode.sv */
// CLINT request decoder
`timescale 1ns/1ps
`default_nettype none

module clint_req_decode
  import clint_cfg_pkg::*;
  import clint_reg_pkg::*;
(
  // AXI4-Lite request channels
  input  logic                  s_awvalid_i,
  input  logic [AXI_ADDR_W-1:0] s_awaddr_i,
  output logic                  s_awready_o,
  input  logic                  s_wvalid_i,
  input  logic [AXI_DATA_W-1:0] s_wdata_i,
  input  logic [AXI_STRB_W-1:0] s_wstrb_i,
  output logic                  s_wready_o,
  input  logic                  s_arvalid_i,
  input  logic [AXI_ADDR_W-1:0] s_araddr_i,
  output logic                  s_arready_o,
  // Response channel occupancy
  input  logic                  b_busy_i,
  input  logic                  r_busy_i,
  // Write strobes to the hart controllers
  output logic [NUM_HARTS-1:0]  wr_msip_o,
  output logic [NUM_HARTS-1:0]  wr_cmp_lo_o,
  output logic [NUM_HARTS-1:0]  wr_cmp_hi_o,
  output logic [AXI_DATA_W-1:0] wdata_o,
  output logic [AXI_STRB_W-1:0] wstrb_o,
  // Requests to the response generator
  output logic                  wr_done_o,
  output logic                  wr_err_o,
  output logic                  rd_req_o,
  output logic [1:0]            rd_region_o,
  output logic [HART_IDX_W-1:0] rd_hart_o,
  output logic                  rd_half_o,
  output logic                  rd_err_o
);

  clint_addr_u waddr;
  clint_addr_u raddr;
  logic        wr_hs;

  function automatic logic hart_ok(input logic [HART_IDX_W-1:0] hart);
    return 32'(hart) < NUM_HARTS;
  endfunction

  assign waddr = s_awaddr_i;
  assign raddr = s_araddr_i;

  // ------------------------------------------------------------------
  // Write channel, address and data taken in the same cycle
  // ------------------------------------------------------------------
  assign wr_hs       = s_awvalid_i & s_wvalid_i & ~b_busy_i;
  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;
  assign wr_done_o   = wr_hs;
  assign wdata_o     = s_wdata_i;
  assign wstrb_o     = s_wstrb_i;

  always_comb begin
    wr_msip_o   = '0;
    wr_cmp_lo_o = '0;
    wr_cmp_hi_o = '0;
    wr_err_o    = 1'b0;
    case (waddr.cmp.region)
      REGION_MSIP: begin
        if (hart_ok(waddr.msip.hart)) begin
          wr_msip_o[waddr.msip.hart] = wr_hs;
        end else begin
          wr_err_o = 1'b1;
        end
      end
      REGION_MTIMECMP: begin
        if (!hart_ok(waddr.cmp.hart)) begin
          wr_err_o = 1'b1;
        end else if (waddr.cmp.half) begin
          wr_cmp_hi_o[waddr.cmp.hart] = wr_hs;
        end else begin
          wr_cmp_lo_o[waddr.cmp.hart] = wr_hs;
        end
      end
      // mtime is read only, region 2 is unmapped
      default: wr_err_o = 1'b1;
    endcase
  end

  // ------------------------------------------------------------------
  // Read channel, one read outstanding
  // ------------------------------------------------------------------
  assign s_arready_o = ~r_busy_i;
  assign rd_req_o    = s_arvalid_i & ~r_busy_i;
  assign rd_region_o = raddr.cmp.region;
  assign rd_half_o   = raddr.cmp.half;
  assign rd_hart_o   = (raddr.cmp.region == REGION_MSIP) ? raddr.msip.hart : raddr.cmp.hart;

  always_comb begin
    case (raddr.cmp.region)
      REGION_MSIP,
      REGION_MTIMECMP: rd_err_o = ~hart_ok(rd_hart_o);
      // Single shared counter, hart field must be zero
      REGION_MTIME:    rd_err_o = (raddr.cmp.hart != '0);
      default:         rd_err_o = 1'b1;
    endcase
  end

endmodule : clint_req_decode

`default_nettype wire

/* src/clint_reg_pkg.sv */
// CLINT register map
`default_nettype none

package clint_reg_pkg;

  // ------------------------------------------------------------------
  // Regions, taken from address bits 15:14
  // ------------------------------------------------------------------
  localparam logic [1:0] REGION_MSIP     = 2'd0;
  localparam logic [1:0] REGION_MTIMECMP = 2'd1;
  // Region 2 is unmapped
  localparam logic [1:0] REGION_MTIME    = 2'd3;

  // Timer compare starts out of reach of mtime
  localparam logic [clint_cfg_pkg::MTIME_W-1:0] MTIMECMP_RESET =
    {clint_cfg_pkg::MTIME_W{1'b1}};

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ------------------------------------------------------------------
  // Register address, seen as msip word or as 64-bit half word
  // ------------------------------------------------------------------
  typedef union packed {
    struct packed {
      logic [1:0]                                     region;
      logic [clint_cfg_pkg::AXI_ADDR_W-clint_cfg_pkg::HART_IDX_W-5:0] rsvd;
      logic [clint_cfg_pkg::HART_IDX_W-1:0]           hart;
      logic [1:0]                                     byte_off;
    } msip;
    struct packed {
      logic [1:0]                                     region;
      logic [clint_cfg_pkg::AXI_ADDR_W-clint_cfg_pkg::HART_IDX_W-6:0] rsvd;
      logic [clint_cfg_pkg::HART_IDX_W-1:0]           hart;
      // 0 selects bits 31:0, 1 selects bits 63:32
      logic                                           half;
      logic [1:0]                                     byte_off;
    } cmp;
  } clint_addr_u;

endpackage : clint_reg_pkg

`default_nettype wire

/* src/clint_cfg_pkg.sv */
// CLINT sizing constants
`default_nettype none

package clint_cfg_pkg;

  // Hart array
  localparam int unsigned NUM_HARTS  = 4;
  localparam int unsigned HART_IDX_W = 2;

  // ------------------------------------------------------------------
  // AXI4-Lite slave port
  // ------------------------------------------------------------------
  localparam int unsigned AXI_ADDR_W = 16;
  localparam int unsigned AXI_DATA_W = 32;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;

  // ------------------------------------------------------------------
  // Timer
  // ------------------------------------------------------------------
  // mtime and every mtimecmp share this width and are read as two
  // AXI_DATA_W halves
  localparam int unsigned MTIME_W = 64;

  // rtc_i is asynchronous to clk_i
  localparam int unsigned RTC_SYNC_STAGES = 2;

endpackage : clint_cfg_pkg

`default_nettype wire
